/* Bender.yml */
package:
  name: sd_spi_reader

sources:
  - source/sd_pkg.sv
  - source/sd_cmd_if.sv
  - source/sd_clk_gen.sv
  - source/sd_cmd_tx.sv
  - source/sd_resp_rx.sv
  - source/sd_block_rx.sv
  - source/sd_init_ctrl.sv
  - source/sd_spi_reader.sv
  - target: test
    files:
      - test/sd_spi_asserts.sv
      - test/tb_sd_spi_reader.sv

/* source/sd_block_rx.sv */
`timescale 1ns/10ps

module sd_block_rx #(
  parameter int TOKEN_TIMEOUT = 2048
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       block_start,
  input  logic       rise_tick,
  input  logic       sd_data0,
  output logic       data_valid,
  output logic [7:0] data_byte,
  output logic       block_done,
  output logic       block_timeout
);
  import sd_pkg::*;

  localparam int TW = $clog2(TOKEN_TIMEOUT + 1);
  localparam int BW = $clog2(BLOCK_BYTES);

  typedef enum logic [1:0] {BK_IDLE, BK_TOKEN, BK_DATA, BK_CRC} blk_state_e;

  blk_state_e    state;
  logic [7:0]    shreg;
  logic [7:0]    shreg_nxt;
  logic [2:0]    bit_cnt;
  logic [BW-1:0] byte_cnt;
  logic [TW-1:0] tok_cnt;   // non-token bytes seen so far
  logic          byte_end;

  assign shreg_nxt = {shreg[6:0], sd_data0};  // msb first
  assign byte_end  = rise_tick && (bit_cnt == 3'd7);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state         <= BK_IDLE;
      shreg         <= 8'hFF;
      bit_cnt       <= '0;
      byte_cnt      <= '0;
      tok_cnt       <= '0;
      data_valid    <= 1'b0;
      block_done    <= 1'b0;
      block_timeout <= 1'b0;
    end else begin
      data_valid    <= 1'b0;
      block_done    <= 1'b0;
      block_timeout <= 1'b0;
      if (rise_tick && state != BK_IDLE) bit_cnt <= bit_cnt + 1'b1;
      case (state)
        BK_IDLE: if (block_start) begin
          state   <= BK_TOKEN;
          shreg   <= 8'hFF;
          bit_cnt <= '0;
          tok_cnt <= '0;
        end
        BK_TOKEN: if (rise_tick) begin
          shreg <= shreg_nxt;
          if (shreg_nxt == DATA_TOKEN) begin  // bitwise search, token may be unaligned
            state    <= BK_DATA;
            bit_cnt  <= '0;
            byte_cnt <= '0;
          end else if (byte_end) begin
            if (tok_cnt == TW'(TOKEN_TIMEOUT - 1)) begin
              state         <= BK_IDLE;
              block_done    <= 1'b1;
              block_timeout <= 1'b1;
            end else begin
              tok_cnt <= tok_cnt + 1'b1;
            end
          end
        end
        BK_DATA: if (rise_tick) begin
          shreg <= shreg_nxt;
          if (byte_end) begin
            data_valid <= 1'b1;
            byte_cnt   <= byte_cnt + 1'b1;  // wraps to 0 for the crc bytes
            if (byte_cnt == BW'(BLOCK_BYTES - 1)) state <= BK_CRC;
          end
        end
        BK_CRC: if (byte_end) begin
          byte_cnt <= byte_cnt + 1'b1;
          if (byte_cnt == BW'(1)) begin     // crc16 dropped unchecked
            state      <= BK_IDLE;
            block_done <= 1'b1;
          end
        end
        default: state <= BK_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == BK_DATA && byte_end) data_byte <= shreg_nxt;
  end

endmodule

/* source/sd_clk_gen.sv */
`timescale 1ns/10ps

module sd_clk_gen #(
  parameter int CLK_DIV_SLOW = 125,
  parameter int CLK_DIV_FAST = 2
) (
  input  logic clk,
  input  logic rst_n,
  input  logic clk_en,
  input  logic fast,
  output logic sd_clk,
  output logic fall_tick,
  output logic rise_tick
);

  // the slow divider is the larger one and sets the counter width
  localparam int CW = $clog2(CLK_DIV_SLOW + 1);

  logic [CW-1:0] cnt;
  logic [CW-1:0] reload;
  logic          toggle;

  assign reload = fast ? CW'(CLK_DIV_FAST - 1) : CW'(CLK_DIV_SLOW - 1);
  assign toggle = clk_en && (cnt == '0);

  // both ticks mark the clk edge on which sd_clk changes
  assign rise_tick = toggle && !sd_clk;
  assign fall_tick = toggle && sd_clk;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt    <= CW'(CLK_DIV_SLOW - 1);
      sd_clk <= 1'b0;
    end else if (!clk_en) begin
      cnt    <= reload;  // park low, restart with a full half period
      sd_clk <= 1'b0;
    end else if (toggle) begin
      cnt    <= reload;  // new divider only takes effect here
      sd_clk <= ~sd_clk;
    end else begin
      cnt <= cnt - 1'b1;
    end
  end

endmodule

/* source/sd_cmd_if.sv */
`timescale 1ns/10ps

interface sd_cmd_if;
  import sd_pkg::*;

  // request side, held by the controller until done
  logic       start;
  cmd_index_t index;
  cmd_arg_t   arg;
  resp_kind_e kind;

  logic sent;     // last frame bit is out

  // response side
  logic  done;
  resp_t resp;
  logic  timeout;  // valid with done

  modport ctrl (output start, index, arg, kind, input done, resp, timeout);

  modport tx (input start, index, arg, output sent);

  modport rx (input sent, kind, output done, resp, timeout);

endinterface

/* source/sd_cmd_tx.sv */
`timescale 1ns/10ps

module sd_cmd_tx (
  input  logic clk,
  input  logic rst_n,
  sd_cmd_if.tx cmd,
  input  logic fall_tick,
  output logic sd_cmd
);
  import sd_pkg::*;

  localparam int BODY_BITS = FRAME_BITS - 8;  // start bits, index, argument

  logic [BODY_BITS-1:0] shreg;
  logic [6:0]           crc;
  logic [5:0]           bit_cnt;
  logic                 busy;
  logic                 fb;

  assign fb = shreg[BODY_BITS-1] ^ crc[6];  // crc feedback for the bit going out

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy     <= 1'b0;
      bit_cnt  <= '0;
      crc      <= '0;
      sd_cmd   <= 1'b1;
      cmd.sent <= 1'b0;
    end else begin
      cmd.sent <= 1'b0;
      if (cmd.start) begin
        busy    <= 1'b1;
        bit_cnt <= '0;
        crc     <= '0;
      end else if (busy && fall_tick) begin
        bit_cnt <= bit_cnt + 1'b1;
        if (bit_cnt < 6'(BODY_BITS)) begin
          sd_cmd <= shreg[BODY_BITS-1];
          crc    <= {crc[5:0], 1'b0} ^ (fb ? CRC7_POLY : 7'h00);
        end else if (bit_cnt < 6'(FRAME_BITS - 1)) begin
          sd_cmd <= crc[6];            // crc goes out msb first
          crc    <= {crc[5:0], 1'b0};
        end else if (bit_cnt == 6'(FRAME_BITS - 1)) begin
          sd_cmd <= 1'b1;              // end bit, line then stays high
        end else begin
          busy     <= 1'b0;
          cmd.sent <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (cmd.start) begin
      shreg <= {2'b01, cmd.index, cmd.arg};
    end else if (busy && fall_tick) begin
      shreg <= {shreg[BODY_BITS-2:0], 1'b0};
    end
  end

endmodule

/* source/sd_init_ctrl.sv */
`timescale 1ns/10ps

module sd_init_ctrl #(
  parameter int POWER_UP_CYCLES = 250000,
  parameter int CMD0_RETRIES    = 10,
  parameter int ACMD41_RETRIES  = 2000
) (
  input  logic             clk,
  input  logic             rst_n,
  sd_cmd_if.ctrl           cmd,
  input  logic             block_done,
  input  logic             block_timeout,
  input  sd_pkg::cmd_arg_t block_addr,
  output logic             clk_en,
  output logic             fast,
  output logic             sd_cs,
  output logic             block_start,
  output logic             ready,
  output logic             error,
  output logic             high_capacity
);
  import sd_pkg::*;

  localparam int PW          = $clog2(POWER_UP_CYCLES + 1);
  localparam int MAX_RETRIES = (CMD0_RETRIES > ACMD41_RETRIES) ? CMD0_RETRIES : ACMD41_RETRIES;
  localparam int RW          = $clog2(MAX_RETRIES + 1);

  init_state_e   state;
  logic [PW-1:0] pwr_cnt;
  logic [RW-1:0] retry_cnt;
  logic          waiting;   // command in flight
  logic          got;       // its response is here this cycle
  logic          ok;        // response without timeout
  logic [7:0]    r1;

  assign r1     = cmd.resp[RESP_BITS-1 -: R1_BITS];
  assign got    = waiting && cmd.done;
  assign ok     = got && !cmd.timeout;
  assign clk_en = (state != ST_READY) && (state != ST_ERROR);

  // receiver has to be armed right away, the token may follow the r1 closely
  assign block_start = (state == ST_CMD17) && ok && (r1 == 8'h00);

  // command fields follow the state, so they hold from start until done
  always_comb begin
    cmd.index = CMD_GO_IDLE;
    cmd.arg   = '0;
    cmd.kind  = RESP_R1;
    case (state)
      ST_CMD8: begin
        cmd.index = CMD_SEND_IF_COND;
        cmd.arg   = IF_COND_ARG;
        cmd.kind  = RESP_LONG;
      end
      ST_CMD58_A, ST_CMD58_B: begin
        cmd.index = CMD_READ_OCR;
        cmd.kind  = RESP_LONG;
      end
      ST_CMD55:  cmd.index = CMD_APP_CMD;
      ST_ACMD41: begin
        cmd.index = CMD_SD_SEND_OP_COND;
        cmd.arg   = HCS_ARG;
      end
      ST_CMD16: begin
        cmd.index = CMD_SET_BLOCKLEN;
        cmd.arg   = cmd_arg_t'(BLOCK_BYTES);
      end
      ST_CMD17: begin
        cmd.index = CMD_READ_SINGLE;
        cmd.arg   = high_capacity ? block_addr : block_addr << 9;  // sdsc wants bytes
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state         <= ST_POWER_UP;
      pwr_cnt       <= '0;
      retry_cnt     <= '0;
      waiting       <= 1'b0;
      cmd.start     <= 1'b0;
      sd_cs         <= 1'b1;
      fast          <= 1'b0;
      ready         <= 1'b0;
      error         <= 1'b0;
      high_capacity <= 1'b0;
    end else begin
      cmd.start <= 1'b0;
      if (got) waiting <= 1'b0;
      if (!waiting && state inside {[ST_CMD0:ST_CMD17]}) begin
        cmd.start <= 1'b1;
        waiting   <= 1'b1;
      end
      case (state)
        ST_POWER_UP: begin
          if (pwr_cnt == PW'(POWER_UP_CYCLES - 1)) begin
            sd_cs <= 1'b0;
            state <= ST_CMD0;
          end else begin
            pwr_cnt <= pwr_cnt + 1'b1;
          end
        end
        ST_CMD0: if (got) begin
          if (ok && r1 == R1_IDLE) begin
            retry_cnt <= '0;
            state     <= ST_CMD8;
          end else if (retry_cnt == RW'(CMD0_RETRIES)) begin
            state <= ST_ERROR;
          end else begin
            retry_cnt <= retry_cnt + 1'b1;  // silent or not idle yet, send again
          end
        end
        ST_CMD8: if (got) begin
          state <= (ok && (r1 == R1_ILLEGAL ||
                   (r1 == R1_IDLE && cmd.resp[11:0] == IF_COND_ARG[11:0]))) ?
                   ST_CMD58_A : ST_ERROR;
        end
        ST_CMD58_A: if (got) state <= (ok && r1 == R1_IDLE) ? ST_CMD55 : ST_ERROR;
        ST_CMD55:   if (got) state <= (ok && r1[7:1] == 7'd0) ? ST_ACMD41 : ST_ERROR;
        ST_ACMD41: if (got) begin
          if (ok && r1 == 8'h00) begin
            state <= ST_CMD58_B;
          end else if (ok && r1 == R1_IDLE && retry_cnt != RW'(ACMD41_RETRIES)) begin
            retry_cnt <= retry_cnt + 1'b1;  // card still busy
            state     <= ST_CMD55;
          end else begin
            state <= ST_ERROR;
          end
        end
        ST_CMD58_B: if (got) begin
          if (ok && r1 == 8'h00) begin
            high_capacity <= cmd.resp[30];  // ccs
            fast          <= 1'b1;
            state         <= ST_CMD16;
          end else begin
            state <= ST_ERROR;
          end
        end
        ST_CMD16: if (got) state <= (ok && r1 == 8'h00) ? ST_CMD17 : ST_ERROR;
        ST_CMD17: if (got) state <= block_start ? ST_BLOCK : ST_ERROR;
        ST_BLOCK: if (block_done) state <= block_timeout ? ST_ERROR : ST_READY;
        ST_READY: begin
          ready <= 1'b1;
          sd_cs <= 1'b1;
        end
        ST_ERROR: begin
          error <= 1'b1;
          sd_cs <= 1'b1;
        end
        default: state <= ST_ERROR;
      endcase
    end
  end

endmodule

/* source/sd_pkg.sv */
package sd_pkg;

  // command frame and response geometry
  localparam int FRAME_BITS = 48;
  localparam int RESP_BITS  = 40;
  localparam int R1_BITS    = 8;

  typedef logic [5:0]           cmd_index_t;
  typedef logic [31:0]          cmd_arg_t;
  typedef logic [RESP_BITS-1:0] resp_t;      // r1 byte in the top bits, payload below

  typedef enum logic {
    RESP_R1,    // 8 bit response
    RESP_LONG   // r3 / r7, 40 bits
  } resp_kind_e;

  localparam cmd_index_t CMD_GO_IDLE         = 6'd0;
  localparam cmd_index_t CMD_SEND_IF_COND    = 6'd8;
  localparam cmd_index_t CMD_SET_BLOCKLEN    = 6'd16;
  localparam cmd_index_t CMD_READ_SINGLE     = 6'd17;
  localparam cmd_index_t CMD_SD_SEND_OP_COND = 6'd41;  // sent after CMD_APP_CMD
  localparam cmd_index_t CMD_APP_CMD         = 6'd55;
  localparam cmd_index_t CMD_READ_OCR        = 6'd58;

  localparam cmd_arg_t IF_COND_ARG = 32'h0000_01AA;  // 2.7-3.6 V, check pattern aa
  localparam cmd_arg_t HCS_ARG     = 32'h4000_0000;  // host supports sdhc / sdxc

  localparam int         BLOCK_BYTES = 512;
  localparam logic [7:0] DATA_TOKEN  = 8'hFE;
  localparam logic [7:0] R1_IDLE     = 8'h01;
  localparam logic [7:0] R1_ILLEGAL  = 8'h05;  // idle + illegal command, old cards

  localparam logic [6:0] CRC7_POLY = 7'h09;    // x^7 + x^3 + 1

  typedef enum logic [3:0] {
    ST_POWER_UP,
    ST_CMD0,
    ST_CMD8,
    ST_CMD58_A,
    ST_CMD55,
    ST_ACMD41,
    ST_CMD58_B,
    ST_CMD16,
    ST_CMD17,
    ST_BLOCK,
    ST_READY,
    ST_ERROR
  } init_state_e;

endpackage

/* source/sd_resp_rx.sv */
`timescale 1ns/10ps

module sd_resp_rx #(
  parameter int RESP_TIMEOUT = 64
) (
  input  logic clk,
  input  logic rst_n,
  sd_cmd_if.rx cmd,
  input  logic rise_tick,
  input  logic sd_data0
);
  import sd_pkg::*;

  localparam int TW = $clog2(RESP_TIMEOUT + 1);

  typedef enum logic [1:0] {RX_IDLE, RX_WAIT, RX_COLLECT} rx_state_e;

  rx_state_e     state;
  logic [TW-1:0] wait_cnt;
  logic [5:0]    bit_cnt;   // index of the bit being sampled
  logic [5:0]    last_bit;
  resp_t         shreg;
  logic          finish;
  logic          expire;

  assign last_bit = (cmd.kind == RESP_R1) ? 6'(R1_BITS - 1) : 6'(RESP_BITS - 1);
  assign finish   = rise_tick && (state == RX_COLLECT) && (bit_cnt == last_bit);
  assign expire   = rise_tick && (state == RX_WAIT) && sd_data0 &&
                    (wait_cnt == TW'(RESP_TIMEOUT - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state       <= RX_IDLE;
      wait_cnt    <= '0;
      bit_cnt     <= '0;
      cmd.done    <= 1'b0;
      cmd.timeout <= 1'b0;
    end else begin
      cmd.done <= 1'b0;
      case (state)
        RX_IDLE: if (cmd.sent) begin
          state    <= RX_WAIT;
          wait_cnt <= '0;
        end
        RX_WAIT: if (rise_tick) begin
          if (!sd_data0) begin       // r1 msb is always 0
            state   <= RX_COLLECT;
            bit_cnt <= 6'd1;
          end else if (expire) begin
            state       <= RX_IDLE;
            cmd.done    <= 1'b1;
            cmd.timeout <= 1'b1;
          end else begin
            wait_cnt <= wait_cnt + 1'b1;
          end
        end
        RX_COLLECT: if (finish) begin
          state       <= RX_IDLE;
          cmd.done    <= 1'b1;
          cmd.timeout <= 1'b0;
        end else if (rise_tick) begin
          bit_cnt <= bit_cnt + 1'b1;
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rise_tick && (state == RX_COLLECT || (state == RX_WAIT && !sd_data0))) begin
      shreg <= {shreg[RESP_BITS-2:0], sd_data0};
    end
    if (finish) begin
      // short response lands in the r1 byte, payload reads as all ones
      cmd.resp <= (cmd.kind == RESP_R1) ?
                  {shreg[R1_BITS-2:0], sd_data0, {(RESP_BITS - R1_BITS){1'b1}}} :
                  {shreg[RESP_BITS-2:0], sd_data0};
    end else if (expire) begin
      cmd.resp <= '1;
    end
  end

endmodule

/* source/sd_spi_reader.sv */
`timescale 1ns/10ps

module sd_spi_reader #(
  parameter int CLK_DIV_SLOW    = 125,     // 100 mhz to 400 khz
  parameter int CLK_DIV_FAST    = 2,       // 25 mhz
  parameter int POWER_UP_CYCLES = 250000,
  parameter int RESP_TIMEOUT    = 64,
  parameter int TOKEN_TIMEOUT   = 2048,
  parameter int CMD0_RETRIES    = 10,
  parameter int ACMD41_RETRIES  = 2000
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        sd_data0,
  input  logic [31:0] block_addr,
  output logic        sd_clk,
  output logic        sd_cs,
  output logic        sd_cmd,
  output logic        data_valid,
  output logic [7:0]  data_byte,
  output logic        ready,
  output logic        error,
  output logic        high_capacity
);

  logic clk_en;
  logic fast;
  logic fall_tick;
  logic rise_tick;
  logic block_start;
  logic block_done;
  logic block_timeout;

  sd_cmd_if cmd_bus ();

  sd_clk_gen #(
    .CLK_DIV_SLOW (CLK_DIV_SLOW),
    .CLK_DIV_FAST (CLK_DIV_FAST)
  ) u_clk_gen (
    .clk       (clk),
    .rst_n     (rst_n),
    .clk_en    (clk_en),
    .fast      (fast),
    .sd_clk    (sd_clk),
    .fall_tick (fall_tick),
    .rise_tick (rise_tick)
  );

  sd_cmd_tx u_cmd_tx (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd       (cmd_bus.tx),
    .fall_tick (fall_tick),
    .sd_cmd    (sd_cmd)
  );

  sd_resp_rx #(
    .RESP_TIMEOUT (RESP_TIMEOUT)
  ) u_resp_rx (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd       (cmd_bus.rx),
    .rise_tick (rise_tick),
    .sd_data0  (sd_data0)
  );

  sd_block_rx #(
    .TOKEN_TIMEOUT (TOKEN_TIMEOUT)
  ) u_block_rx (
    .clk           (clk),
    .rst_n         (rst_n),
    .block_start   (block_start),
    .rise_tick     (rise_tick),
    .sd_data0      (sd_data0),
    .data_valid    (data_valid),
    .data_byte     (data_byte),
    .block_done    (block_done),
    .block_timeout (block_timeout)
  );

  sd_init_ctrl #(
    .POWER_UP_CYCLES (POWER_UP_CYCLES),
    .CMD0_RETRIES    (CMD0_RETRIES),
    .ACMD41_RETRIES  (ACMD41_RETRIES)
  ) u_init_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .cmd           (cmd_bus.ctrl),
    .block_done    (block_done),
    .block_timeout (block_timeout),
    .block_addr    (block_addr),
    .clk_en        (clk_en),
    .fast          (fast),
    .sd_cs         (sd_cs),
    .block_start   (block_start),
    .ready         (ready),
    .error         (error),
    .high_capacity (high_capacity)
  );

endmodule

/* src.f */
source/sd_pkg.sv
source/sd_cmd_if.sv
source/sd_clk_gen.sv
source/sd_cmd_tx.sv
source/sd_resp_rx.sv
source/sd_block_rx.sv
source/sd_init_ctrl.sv
source/sd_spi_reader.sv
test/sd_spi_asserts.sv
test/tb_sd_spi_reader.sv

/* test/sd_spi_asserts.sv */
`timescale 1ns/10ps

module sd_spi_asserts (
  input logic clk,
  input logic rst_n,
  input logic sd_cs,
  input logic sd_cmd,
  input logic data_valid,
  input logic ready,
  input logic error
);

  int fail_cnt = 0;

  // card deselected means the command line idles high
  cmd_idle_when_deselected: assert property (
    @(posedge clk) disable iff (!rst_n) sd_cs |-> sd_cmd
  ) else begin
    $error("sd_cmd low while sd_cs is high");
    fail_cnt++;
  end

  valid_single_cycle: assert property (
    @(posedge clk) disable iff (!rst_n) data_valid |=> !data_valid
  ) else begin
    $error("data_valid high for two clocks");
    fail_cnt++;
  end

  ready_error_exclusive: assert property (
    @(posedge clk) disable iff (!rst_n) !(ready && error)
  ) else begin
    $error("ready and error both high");
    fail_cnt++;
  end

endmodule

bind sd_spi_reader sd_spi_asserts u_asserts (
  .clk        (clk),
  .rst_n      (rst_n),
  .sd_cs      (sd_cs),
  .sd_cmd     (sd_cmd),
  .data_valid (data_valid),
  .ready      (ready),
  .error      (error)
);

/* test/tb_sd_spi_reader.sv */
`timescale 1ns/10ps

module tb_sd_spi_reader;

  localparam int CMD0_RETRIES   = 4;
  localparam int ACMD41_RETRIES = 4;
  localparam int BLOCK_BYTES    = 512;
  localparam int WAIT_LIMIT     = 200000;  // clk cycles per run

  localparam int MODE_OK       = 0;
  localparam int MODE_SILENT   = 1;
  localparam int MODE_BAD_ECHO = 2;
  localparam int MODE_BUSY     = 3;

  logic        clk;
  logic        rst_n;
  logic        sd_data0;
  logic [31:0] block_addr;
  logic        sd_clk;
  logic        sd_cs;
  logic        sd_cmd;
  logic        data_valid;
  logic [7:0]  data_byte;
  logic        ready;
  logic        error;
  logic        high_capacity;

  int value_errs;
  int other_errs;

  // card script
  int mode;
  int busy_left;
  bit ccs;
  bit card_idle;

  bit [47:0] rx_frame;
  int        rx_cnt;
  bit        in_frame;
  bit        bitq[$];       // bits the card shifts out on sd_data0
  int        seen_idx[$];
  int        exp_idx[$];
  logic [7:0] exp_bytes[$];
  int        bytes_seen;

  // sd_clk half period tracking
  bit  check_clk;
  bit  have_last;
  bit  fast_seen;
  int  switch_last;
  int  clk_edges;
  time last_t;
  int  hp;

  sd_spi_reader #(
    .CLK_DIV_SLOW    (2),
    .CLK_DIV_FAST    (1),
    .POWER_UP_CYCLES (20),
    .CMD0_RETRIES    (CMD0_RETRIES),
    .ACMD41_RETRIES  (ACMD41_RETRIES)
  ) UUT (
    .clk           (clk),
    .rst_n         (rst_n),
    .sd_data0      (sd_data0),
    .block_addr    (block_addr),
    .sd_clk        (sd_clk),
    .sd_cs         (sd_cs),
    .sd_cmd        (sd_cmd),
    .data_valid    (data_valid),
    .data_byte     (data_byte),
    .ready         (ready),
    .error         (error),
    .high_capacity (high_capacity)
  );

  always #10 clk = ~clk;

  // x^7 + x^3 + 1 over the 40 bits of start, index and argument
  function automatic logic [6:0] crc7_ref(input logic [39:0] d);
    logic [6:0] c;
    logic       fb;
    c = '0;
    for (int i = 39; i >= 0; i--) begin
      fb   = d[i] ^ c[6];
      c    = {c[5:0], fb};
      c[3] = c[3] ^ fb;
    end
    return c;
  endfunction

  // sdhc takes a block number, sdsc a byte address
  function automatic logic [31:0] read_arg_ref(input logic [31:0] addr, input bit hc);
    return hc ? addr : {addr[22:0], 9'b0};
  endfunction

  task automatic report_mismatch(input string msg);
    value_errs++;
    $display("Fail at %0t ns: %s", $time, msg);
  endtask

  task automatic report_problem(input string msg);
    other_errs++;
    $display("Problem at %0t ns: %s", $time, msg);
  endtask

  task automatic push_byte(input logic [7:0] b);
    for (int i = 7; i >= 0; i--) bitq.push_back(b[i]);
  endtask

  task automatic check_frame(input bit [47:0] f);
    if (f[47:46] != 2'b01) report_mismatch($sformatf("start bits %b", f[47:46]));
    if (f[7:1] != crc7_ref(f[47:8]))
      report_mismatch($sformatf("crc7 %h expected %h", f[7:1], crc7_ref(f[47:8])));
    if (f[0] != 1'b1) report_mismatch("end bit is 0");
    if (f[45:40] == 6'd17 && f[39:8] != read_arg_ref(block_addr, ccs))
      report_mismatch($sformatf("cmd17 arg %h expected %h", f[39:8],
                                read_arg_ref(block_addr, ccs)));
  endtask

  // card side of one command, response goes into the bit queue
  task automatic answer_frame(input bit [47:0] f);
    logic [7:0] b;
    int         idx;
    idx = f[45:40];
    check_frame(f);
    seen_idx.push_back(idx);
    if (mode == MODE_SILENT) return;
    repeat ($urandom_range(8, 1)) bitq.push_back(1'b1);
    case (idx)
      0: begin
        card_idle = 1;
        push_byte(8'h01);
      end
      8: begin
        push_byte(8'h01);
        push_byte(8'h00);
        push_byte(8'h00);
        push_byte(8'h01);
        push_byte(mode == MODE_BAD_ECHO ? 8'h55 : f[15:8]);
      end
      58: begin
        push_byte(card_idle ? 8'h01 : 8'h00);
        push_byte({1'b1, ccs, 6'b0});
        push_byte(8'hFF);
        push_byte(8'h80);
        push_byte(8'h00);
      end
      55: push_byte(card_idle ? 8'h01 : 8'h00);
      41: begin
        if (busy_left > 0) begin
          busy_left--;
          push_byte(8'h01);
        end else begin
          card_idle = 0;
          push_byte(8'h00);
        end
      end
      16: push_byte(8'h00);
      17: begin
        push_byte(8'h00);
        repeat ($urandom_range(4, 1)) push_byte(8'hFF);
        push_byte(8'hFE);            // data token
        for (int i = 0; i < BLOCK_BYTES; i++) begin
          b = $urandom_range(255, 0);
          exp_bytes.push_back(b);
          push_byte(b);
        end
        push_byte($urandom_range(255, 0));  // crc16, not checked by the DUT
        push_byte($urandom_range(255, 0));
      end
      default: push_byte(8'h04);
    endcase
  endtask

  // card samples cmd on the rising sd_clk edge
  always @(posedge sd_clk) begin
    if (rst_n && !sd_cs) begin
      if (!in_frame) begin
        if (sd_cmd == 1'b0) begin
          in_frame = 1;
          rx_frame = '0;
          rx_cnt   = 1;
        end
      end else begin
        rx_frame = {rx_frame[46:0], sd_cmd};
        rx_cnt++;
        if (rx_cnt == 48) begin
          in_frame = 0;
          answer_frame(rx_frame);
        end
      end
    end
  end

  // and shifts its reply on the falling edge
  always @(negedge sd_clk) begin
    if (bitq.size() > 0) sd_data0 <= bitq.pop_front();
    else sd_data0 <= 1'b1;
  end

  // compare process for the block bytes
  always @(negedge clk) begin
    if (rst_n && data_valid) begin
      bytes_seen++;
      if (exp_bytes.size() == 0) begin
        report_problem("data_valid strobe with no byte left in the block");
      end else if (data_byte !== exp_bytes[0]) begin
        report_mismatch($sformatf("byte %0d is %h expected %h", bytes_seen - 1,
                                  data_byte, exp_bytes[0]));
        void'(exp_bytes.pop_front());
      end else begin
        void'(exp_bytes.pop_front());
      end
    end
  end

  // half periods in clk cycles, 2 before the switch and 1 after
  always @(sd_clk) begin
    if (rst_n) clk_edges++;
    if (rst_n && check_clk && bytes_seen < BLOCK_BYTES) begin
      if (have_last) begin
        hp = int'(($time - last_t) / 20);
        if (!fast_seen) begin
          if (hp == 1) begin
            fast_seen   = 1;
            switch_last = (seen_idx.size() > 0) ? seen_idx[$] : -1;
          end else if (hp != 2) begin
            report_mismatch($sformatf("slow half period of %0d cycles", hp));
          end
        end else if (hp != 1) begin
          report_mismatch($sformatf("fast half period of %0d cycles", hp));
        end
      end
      have_last = 1;
      last_t    = $time;
    end
  end

  task automatic end_run;
    int assert_errs;
    assert_errs = UUT.u_asserts.fail_cnt;
    $display("errors: %0d value mismatches, %0d other failures, %0d assertion failures",
             value_errs, other_errs, assert_errs);
    if (value_errs + other_errs + assert_errs == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  endtask

  task automatic run_case(input int m, input int busy, input bit hc);
    int cyc;
    mode      = m;
    busy_left = busy;
    ccs       = hc;
    card_idle = 1;
    in_frame  = 0;
    bitq.delete();
    seen_idx.delete();
    exp_idx.delete();
    exp_bytes.delete();
    bytes_seen = 0;
    check_clk  = (m == MODE_OK);
    have_last  = 0;
    fast_seen  = 0;
    clk_edges  = 0;

    // expected command order
    if (m == MODE_SILENT) begin
      repeat (CMD0_RETRIES + 1) exp_idx.push_back(0);
    end else begin
      exp_idx.push_back(0);
      exp_idx.push_back(8);
      if (m != MODE_BAD_ECHO) begin
        exp_idx.push_back(58);
        repeat ((m == MODE_BUSY) ? ACMD41_RETRIES + 1 : busy + 1) begin
          exp_idx.push_back(55);
          exp_idx.push_back(41);
        end
        if (m == MODE_OK) begin
          exp_idx.push_back(58);
          exp_idx.push_back(16);
          exp_idx.push_back(17);
        end
      end
    end

    @(negedge clk);
    rst_n      = 1'b0;
    block_addr = $urandom;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    if (sd_cs !== 1'b1 || sd_cmd !== 1'b1)
      report_mismatch("sd_cs or sd_cmd not high after reset");
    if (ready !== 1'b0 || error !== 1'b0 || data_valid !== 1'b0)
      report_mismatch("ready, error or data_valid not low after reset");
    if (sd_clk !== 1'b0 || high_capacity !== 1'b0)
      report_mismatch("sd_clk or high_capacity not low after reset");

    for (cyc = 0; cyc < WAIT_LIMIT && !(ready || error); cyc++) begin
      @(negedge clk);
      if (!sd_cs && clk_edges == 0) report_mismatch("sd_cs low before sd_clk toggled");
    end
    if (cyc == WAIT_LIMIT) begin
      report_problem("timed out waiting for ready or error");
    end else begin
      if (seen_idx.size() != exp_idx.size())
        report_mismatch($sformatf("%0d frames seen, %0d expected", seen_idx.size(),
                                  exp_idx.size()));
      for (int i = 0; i < seen_idx.size() && i < exp_idx.size(); i++)
        if (seen_idx[i] != exp_idx[i])
          report_mismatch($sformatf("frame %0d is cmd%0d expected cmd%0d", i,
                                    seen_idx[i], exp_idx[i]));
      if (m == MODE_OK) begin
        if (ready !== 1'b1 || error !== 1'b0) report_mismatch("ready not reached");
        if (bytes_seen != BLOCK_BYTES)
          report_mismatch($sformatf("%0d data strobes", bytes_seen));
        if (high_capacity !== hc) report_mismatch("high_capacity differs from card ccs");
        if (!fast_seen) report_mismatch("sd_clk never switched to fast");
        else if (switch_last != 58)
          report_mismatch($sformatf("clock switch after cmd%0d", switch_last));
      end else begin
        if (error !== 1'b1 || ready !== 1'b0) report_mismatch("error not raised");
        if (bytes_seen != 0) report_mismatch("data strobes on an error run");
      end
    end
  endtask

  initial begin
    void'($urandom(5371));
    clk        = 1'b0;
    rst_n      = 1'b0;
    sd_data0   = 1'b1;
    block_addr = '0;
    value_errs = 0;
    other_errs = 0;
    run_case(MODE_OK, 2, 1'b1);
    run_case(MODE_OK, 3, 1'b0);
    run_case(MODE_SILENT, 0, 1'b1);
    run_case(MODE_BAD_ECHO, 0, 1'b1);
    run_case(MODE_BUSY, ACMD41_RETRIES + 2, 1'b1);
    end_run();
  end

endmodule
